// File: Bender.yml
package:
  name: rv_stage_id

sources:
  - files:
      - rv_id_pkg.sv
      - rv_decode_if.sv
      - rv_decoder.sv
      - rv_regfile.sv
      - rv_id_ex_reg.sv
      - rv_stage_id.sv
  - target: test
    files:
      - rv_stage_id_chk.sv
      - tb_rv_stage_id.sv

// File: rv_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded control bundle, combinational from decoder to ID/EX register
interface rv_decode_if #(
  parameter int xlen = 32
);
  import rv_id_pkg::*;

  logic            reg_write;
  logic            mem_read;
  logic            mem_write;
  alu_a_sel_e      alu_a_src;
  // High selects the immediate as operand B
  logic            alu_b_src;
  res_src_e        res_src;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            invalid;
  reg_addr_t       rd;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm;

  modport decoder (
    output reg_write, mem_read, mem_write,
    output alu_a_src, alu_b_src, res_src,
    output is_branch, is_jal, is_jalr, invalid,
    output rd, funct3, funct7, imm
  );

  modport pipe (
    input reg_write, mem_read, mem_write,
    input alu_a_src, alu_b_src, res_src,
    input is_branch, is_jal, is_jalr, invalid,
    input rd, funct3, funct7, imm
  );

endinterface

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
  parameter int xlen = 32
) (
  input  rv_id_pkg::instr_t    instr,
  rv_decode_if.decoder         dec,
  output rv_id_pkg::reg_addr_t rs1,
  output rv_id_pkg::reg_addr_t rs2,
  output logic                 rs1_used,
  output logic                 rs2_used
);
  import rv_id_pkg::*;

  imm_fmt_e    imm_fmt;
  logic [31:0] imm_raw;

  // Fixed RV32I field positions
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign dec.rd     = instr[11:7];
  assign dec.funct3 = instr[14:12];
  assign dec.funct7 = instr[31:25];

  always_comb begin
    dec.reg_write = 1'b0;
    dec.mem_read  = 1'b0;
    dec.mem_write = 1'b0;
    dec.alu_a_src = ALU_A_RS1;
    dec.alu_b_src = 1'b0;
    dec.res_src   = RES_ALU;
    dec.is_branch = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.invalid   = 1'b0;
    rs1_used      = 1'b0;
    rs2_used      = 1'b0;
    imm_fmt       = IMM_I;

    case (instr[6:0])
      OPC_OP: begin
        dec.reg_write = 1'b1;
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.reg_write = 1'b1;
        dec.alu_b_src = 1'b1;
        rs1_used      = 1'b1;
      end
      OPC_LOAD: begin
        dec.reg_write = 1'b1;
        dec.mem_read  = 1'b1;
        dec.alu_b_src = 1'b1;
        dec.res_src   = RES_MEM;
        rs1_used      = 1'b1;
      end
      OPC_STORE: begin
        dec.mem_write = 1'b1;
        dec.alu_b_src = 1'b1;
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
        imm_fmt       = IMM_S;
      end
      OPC_BRANCH: begin
        dec.is_branch = 1'b1;
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
        imm_fmt       = IMM_B;
      end
      OPC_JAL: begin
        dec.reg_write = 1'b1;
        dec.res_src   = RES_PC4;
        dec.is_jal    = 1'b1;
        imm_fmt       = IMM_J;
      end
      OPC_JALR: begin
        dec.reg_write = 1'b1;
        dec.res_src   = RES_PC4;
        dec.is_jalr   = 1'b1;
        rs1_used      = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.reg_write = 1'b1;
        dec.alu_a_src = (instr[6:0] == OPC_LUI) ? ALU_A_ZERO : ALU_A_PC;
        dec.alu_b_src = 1'b1;
        imm_fmt       = IMM_U;
      end
      // Illegal instruction, all enables stay low
      default: dec.invalid = 1'b1;
    endcase
  end

  always_comb begin
    case (imm_fmt)
      IMM_S:   imm_raw = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm_raw = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm_raw = {instr[31:12], 12'b0};
      IMM_J:   imm_raw = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm_raw = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  // Every format keeps its sign in bit 31, widen from there
  assign dec.imm = xlen'($signed(imm_raw));

endmodule

`default_nettype wire

// File: rv_id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_ex_reg #(
  parameter int xlen = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  rv_decode_if.pipe             dec,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic [xlen-1:0]       pc,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic                  m_ready,
  output logic                  m_valid,
  input  logic                  data_hazard_id,
  input  logic                  id_ex_flush,
  output logic                  reg_write_ex,
  output logic                  mem_read_ex,
  output logic                  mem_write_ex,
  output rv_id_pkg::alu_a_sel_e alu_a_src_ex,
  output logic                  alu_b_src_ex,
  output rv_id_pkg::res_src_e   res_src_ex,
  output logic                  is_branch_ex,
  output logic                  is_jal_ex,
  output logic                  is_jalr_ex,
  output logic                  trap_ex,
  output rv_id_pkg::reg_addr_t  rd_ex,
  output logic [2:0]            funct3_ex,
  output logic [6:0]            funct7_ex,
  output logic [xlen-1:0]       rs1_data_ex,
  output logic [xlen-1:0]       rs2_data_ex,
  output logic [xlen-1:0]       imm_ex,
  output logic [xlen-1:0]       pc_ex
);

  logic advance;
  logic accept;

  // A hazard holds the dependent instruction upstream
  assign s_ready = m_ready && !data_hazard_id;
  assign advance = !m_valid || m_ready;
  // Only a completed upstream handshake is captured, so nothing is taken twice
  assign accept  = s_valid && s_ready;

  // Enables of an empty slot stay low, bubbles and flushes included
  always_ff @(posedge clk) begin
    if (!rst_n || id_ex_flush) begin
      m_valid      <= 1'b0;
      reg_write_ex <= 1'b0;
      mem_read_ex  <= 1'b0;
      mem_write_ex <= 1'b0;
      is_branch_ex <= 1'b0;
      is_jal_ex    <= 1'b0;
      is_jalr_ex   <= 1'b0;
      trap_ex      <= 1'b0;
    end else if (advance) begin
      m_valid      <= accept;
      reg_write_ex <= accept && dec.reg_write;
      mem_read_ex  <= accept && dec.mem_read;
      mem_write_ex <= accept && dec.mem_write;
      is_branch_ex <= accept && dec.is_branch;
      is_jal_ex    <= accept && dec.is_jal;
      is_jalr_ex   <= accept && dec.is_jalr;
      trap_ex      <= accept && dec.invalid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !id_ex_flush) begin
      alu_a_src_ex <= dec.alu_a_src;
      alu_b_src_ex <= dec.alu_b_src;
      res_src_ex   <= dec.res_src;
      rd_ex        <= dec.rd;
      funct3_ex    <= dec.funct3;
      funct7_ex    <= dec.funct7;
      rs1_data_ex  <= rs1_data;
      rs2_data_ex  <= rs2_data;
      imm_ex       <= dec.imm;
      pc_ex        <= pc;
    end
  end

endmodule

`default_nettype wire

// File: rv_id_pkg.sv
`default_nettype none

package rv_id_pkg;

  localparam int NUM_REGS = 32;

  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_addr_t;

  // RV32I major opcodes handled by the decode stage
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ALU operand A source
  typedef enum logic [1:0] {
    ALU_A_RS1  = 2'd0,
    ALU_A_PC   = 2'd1,
    ALU_A_ZERO = 2'd2
  } alu_a_sel_e;

  // Write-back result source
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } res_src_e;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_fmt_e;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
  parameter int xlen = 32
) (
  input  logic                 clk,
  input  rv_id_pkg::reg_addr_t rs1_addr,
  input  rv_id_pkg::reg_addr_t rs2_addr,
  input  logic                 rd_en,
  input  rv_id_pkg::reg_addr_t rd_addr,
  input  logic [xlen-1:0]      rd_data,
  output logic [xlen-1:0]      rs1_data,
  output logic [xlen-1:0]      rs2_data
);
  import rv_id_pkg::*;

  logic [xlen-1:0] regs[NUM_REGS];

  // x0 reads zero, a write-back to the same register in this cycle is forwarded
  function automatic logic [xlen-1:0] read_port(reg_addr_t addr);
    logic [xlen-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (rd_en && rd_addr == addr) begin
      value = rd_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clk) begin
    if (rd_en && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: rv_stage_id.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_id #(
  parameter int xlen = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_hazard_id,
  input  logic                  id_ex_flush,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  rv_id_pkg::instr_t     instr_id,
  input  logic [xlen-1:0]       pc_id,
  input  logic                  reg_write_wb,
  input  rv_id_pkg::reg_addr_t  rd_wb,
  input  logic [xlen-1:0]       rd_data_wb,
  output logic                  m_valid,
  input  logic                  m_ready,
  output logic                  reg_write_ex,
  output logic                  mem_read_ex,
  output logic                  mem_write_ex,
  output rv_id_pkg::alu_a_sel_e alu_a_src_ex,
  output logic                  alu_b_src_ex,
  output rv_id_pkg::res_src_e   res_src_ex,
  output logic                  is_branch_ex,
  output logic                  is_jal_ex,
  output logic                  is_jalr_ex,
  output logic                  trap_ex,
  output rv_id_pkg::reg_addr_t  rd_ex,
  output logic [2:0]            funct3_ex,
  output logic [6:0]            funct7_ex,
  output logic [xlen-1:0]       rs1_data_ex,
  output logic [xlen-1:0]       rs2_data_ex,
  output logic [xlen-1:0]       imm_ex,
  output logic [xlen-1:0]       pc_ex,
  // To the hazard unit
  output rv_id_pkg::reg_addr_t  rs1_id,
  output rv_id_pkg::reg_addr_t  rs2_id,
  output logic                  rs1_used_id,
  output logic                  rs2_used_id
);

  logic [xlen-1:0] rs1_data_id;
  logic [xlen-1:0] rs2_data_id;

  rv_decode_if #(.xlen(xlen)) dec_bus ();

  rv_decoder #(.xlen(xlen)) decoder (
    .instr    (instr_id),
    .dec      (dec_bus.decoder),
    .rs1      (rs1_id),
    .rs2      (rs2_id),
    .rs1_used (rs1_used_id),
    .rs2_used (rs2_used_id)
  );

  rv_regfile #(.xlen(xlen)) regfile (
    .clk      (clk),
    .rs1_addr (rs1_id),
    .rs2_addr (rs2_id),
    .rd_en    (reg_write_wb),
    .rd_addr  (rd_wb),
    .rd_data  (rd_data_wb),
    .rs1_data (rs1_data_id),
    .rs2_data (rs2_data_id)
  );

  rv_id_ex_reg #(.xlen(xlen)) id_ex (
    .clk, .rst_n,
    .dec      (dec_bus.pipe),
    .rs1_data (rs1_data_id),
    .rs2_data (rs2_data_id),
    .pc       (pc_id),
    .s_valid, .s_ready, .m_ready, .m_valid,
    .data_hazard_id, .id_ex_flush,
    .reg_write_ex, .mem_read_ex, .mem_write_ex,
    .alu_a_src_ex, .alu_b_src_ex, .res_src_ex,
    .is_branch_ex, .is_jal_ex, .is_jalr_ex, .trap_ex,
    .rd_ex, .funct3_ex, .funct7_ex,
    .rs1_data_ex, .rs2_data_ex, .imm_ex, .pc_ex
  );

endmodule

`default_nettype wire

// File: rv_stage_id_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_id_chk #(
  parameter int xlen = 32
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 s_ready,
  input logic                 m_valid,
  input logic                 m_ready,
  input logic                 data_hazard_id,
  input logic                 id_ex_flush,
  input logic                 reg_write_ex,
  input logic                 mem_read_ex,
  input logic                 mem_write_ex,
  input logic                 trap_ex,
  input rv_id_pkg::reg_addr_t rd_ex,
  input logic [xlen-1:0]      rs1_data_ex,
  input logic [xlen-1:0]      imm_ex,
  input logic [xlen-1:0]      pc_ex
);

  reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !m_valid)
    else $error("m_valid not low after reset");

  // A stalled item keeps its slot and its contents
  stall_holds_item: assert property (@(posedge clk) disable iff (!rst_n)
      m_valid && !m_ready && !id_ex_flush |=> m_valid &&
      $stable({reg_write_ex, mem_read_ex, mem_write_ex, trap_ex, rd_ex,
               rs1_data_ex, imm_ex, pc_ex}))
    else $error("ID/EX outputs changed during a stall");

  // A hazard holds the upstream and an advancing edge leaves a bubble
  hazard_blocks_ready: assert property (@(posedge clk) disable iff (!rst_n)
      data_hazard_id && (!m_valid || m_ready) |-> !s_ready ##1 !m_valid)
    else $error("s_ready high or no bubble during a data hazard");

endmodule

bind rv_id_ex_reg rv_stage_id_chk #(.xlen(xlen)) id_ex_chk (.*);

`default_nettype wire

// File: tb.f
rv_id_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_id_ex_reg.sv
rv_stage_id.sv
rv_stage_id_chk.sv
tb_rv_stage_id.sv

// File: tb_rv_stage_id.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_stage_id;
  import rv_id_pkg::*;

  localparam int XLEN        = 32;
  localparam int CLK_PERIOD  = 4;
  localparam int NUM_TXN     = 300;
  localparam int INIT_CYCLES = NUM_REGS - 1;

  localparam logic [6:0] KEPT_OPS[9] = '{OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                                         OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};

  // Expected ID/EX contents
  // Care bits mask the fields that the decode rule leaves open
  typedef struct packed {
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic [1:0]      alu_a_src;
    logic            alu_b_src;
    logic [1:0]      res_src;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            trap;
    logic [4:0]      rd;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            care_ops;
    logic            care_res;
    logic            care_imm;
  } item_t;

  logic            clk;
  logic            rst_n;
  logic            data_hazard_id, id_ex_flush;
  logic            s_valid, s_ready, m_valid, m_ready;
  instr_t          instr_id;
  logic [XLEN-1:0] pc_id;
  logic            reg_write_wb;
  reg_addr_t       rd_wb;
  logic [XLEN-1:0] rd_data_wb;
  logic            reg_write_ex, mem_read_ex, mem_write_ex;
  alu_a_sel_e      alu_a_src_ex;
  logic            alu_b_src_ex;
  res_src_e        res_src_ex;
  logic            is_branch_ex, is_jal_ex, is_jalr_ex, trap_ex;
  reg_addr_t       rd_ex;
  logic [2:0]      funct3_ex;
  logic [6:0]      funct7_ex;
  logic [XLEN-1:0] rs1_data_ex, rs2_data_ex, imm_ex, pc_ex;
  reg_addr_t       rs1_id, rs2_id;
  logic            rs1_used_id, rs2_used_id;

  logic [31:0]     lfsr_state = 32'h31b9_8234;
  logic [XLEN-1:0] model_regs[NUM_REGS];
  item_t           expect_q[$];
  item_t           pending;
  logic            acc_now;
  logic            taken_now;
  logic            flush_now;
  int              accepted;
  int              cyc;

  rv_stage_id #(.xlen(XLEN)) dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      // Taps 32 22 2 1
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Register file as seen in the ID stage, same-cycle write-back included
  function automatic logic [XLEN-1:0] read_model(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (reg_write_wb && rd_wb == addr) begin
      return rd_data_wb;
    end
    return model_regs[addr];
  endfunction

  // Source registers read by each class, rs1 in the upper bit
  function automatic logic [1:0] sources_used(instr_t ins);
    case (ins[6:0])
      OPC_OP, OPC_STORE, OPC_BRANCH: return 2'b11;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  function automatic item_t decode_model(instr_t ins, logic [XLEN-1:0] pc);
    item_t       it;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    it           = '0;
    it.rd        = ins[11:7];
    it.funct3    = ins[14:12];
    it.funct7    = ins[31:25];
    it.rs1_data  = read_model(ins[19:15]);
    it.rs2_data  = read_model(ins[24:20]);
    it.pc        = pc;
    it.alu_a_src = ALU_A_RS1;
    it.res_src   = RES_ALU;
    it.care_ops  = 1'b1;
    it.care_res  = 1'b1;
    it.care_imm  = 1'b1;
    case (ins[6:0])
      OPC_OP: begin
        it.reg_write = 1'b1;
        it.care_imm  = 1'b0;
      end
      OPC_OP_IMM: begin
        it.reg_write = 1'b1;
        it.alu_b_src = 1'b1;
        it.imm       = imm_i;
      end
      OPC_LOAD: begin
        it.reg_write = 1'b1;
        it.mem_read  = 1'b1;
        it.alu_b_src = 1'b1;
        it.res_src   = RES_MEM;
        it.imm       = imm_i;
      end
      OPC_STORE: begin
        it.mem_write = 1'b1;
        it.alu_b_src = 1'b1;
        it.imm       = imm_s;
        it.care_res  = 1'b0;
      end
      OPC_BRANCH: begin
        it.is_branch = 1'b1;
        it.imm       = imm_b;
        it.care_ops  = 1'b0;
        it.care_res  = 1'b0;
      end
      OPC_JAL: begin
        it.reg_write = 1'b1;
        it.res_src   = RES_PC4;
        it.is_jal    = 1'b1;
        it.imm       = imm_j;
        it.care_ops  = 1'b0;
      end
      OPC_JALR: begin
        it.reg_write = 1'b1;
        it.res_src   = RES_PC4;
        it.is_jalr   = 1'b1;
        it.imm       = imm_i;
        it.care_ops  = 1'b0;
      end
      OPC_LUI: begin
        it.reg_write = 1'b1;
        it.alu_a_src = ALU_A_ZERO;
        it.alu_b_src = 1'b1;
        it.imm       = imm_u;
      end
      OPC_AUIPC: begin
        it.reg_write = 1'b1;
        it.alu_a_src = ALU_A_PC;
        it.alu_b_src = 1'b1;
        it.imm       = imm_u;
      end
      default: begin
        it.trap     = 1'b1;
        it.care_ops = 1'b0;
        it.care_res = 1'b0;
        it.care_imm = 1'b0;
      end
    endcase
    return it;
  endfunction

  function automatic item_t observe_outputs(item_t exp);
    item_t obs;
    obs           = exp;
    obs.reg_write = reg_write_ex;
    obs.mem_read  = mem_read_ex;
    obs.mem_write = mem_write_ex;
    obs.is_branch = is_branch_ex;
    obs.is_jal    = is_jal_ex;
    obs.is_jalr   = is_jalr_ex;
    obs.trap      = trap_ex;
    obs.rd        = rd_ex;
    obs.funct3    = funct3_ex;
    obs.funct7    = funct7_ex;
    obs.rs1_data  = rs1_data_ex;
    obs.rs2_data  = rs2_data_ex;
    obs.pc        = pc_ex;
    if (exp.care_ops) begin
      obs.alu_a_src = alu_a_src_ex;
      obs.alu_b_src = alu_b_src_ex;
    end
    if (exp.care_res) begin
      obs.res_src = res_src_ex;
    end
    if (exp.care_imm) begin
      obs.imm = imm_ex;
    end
    return obs;
  endfunction

  task automatic report_mismatch(string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic drive_inputs();
    logic [31:0] upper;
    logic [31:0] op_bits;
    logic [31:0] wb_pick;
    instr_t      ins;
    upper   = random_bits(25);
    op_bits = random_bits(7);
    // Three in four use a kept opcode
    if (random_bits(2) != 0) begin
      ins = {upper[24:0], KEPT_OPS[random_bits(4) % 9]};
    end else begin
      ins = {upper[24:0], op_bits[6:0]};
    end
    instr_id       = ins;
    pc_id          = random_bits(30) << 2;
    s_valid        = random_bits(2) != 0;
    m_ready        = random_bits(2) != 0;
    data_hazard_id = random_bits(3) == 0;
    id_ex_flush    = random_bits(4) == 0;
    reg_write_wb   = random_bits(1) != 0;
    wb_pick        = random_bits(5);
    // Hit the rs1 field now and then to exercise the write-through path
    rd_wb          = (random_bits(2) == 0) ? ins[19:15] : wb_pick[4:0];
    rd_data_wb     = random_bits(32);
    if (cyc < INIT_CYCLES) begin
      s_valid      = 1'b0;
      reg_write_wb = 1'b1;
      rd_wb        = reg_addr_t'(cyc + 1);
    end
    if (accepted >= NUM_TXN) begin
      s_valid        = 1'b0;
      m_ready        = 1'b1;
      data_hazard_id = 1'b0;
      id_ex_flush    = 1'b0;
    end
  endtask

  // Runs between edges where every input and output is settled
  task automatic check_cycle();
    item_t      obs;
    logic       exp_ready;
    logic [1:0] exp_used;
    exp_ready = m_ready && !data_hazard_id;
    exp_used  = sources_used(instr_id);
    assert (s_ready === exp_ready)
      else report_mismatch($sformatf("s_ready %b, expected %b", s_ready, exp_ready));
    assert (rs1_id === instr_id[19:15] && rs2_id === instr_id[24:20])
      else report_mismatch($sformatf("rs1_id %0d rs2_id %0d, expected %0d %0d",
                                     rs1_id, rs2_id, instr_id[19:15], instr_id[24:20]));
    assert ({rs1_used_id, rs2_used_id} === exp_used)
      else report_mismatch($sformatf("rs1_used_id/rs2_used_id %b%b, expected %b",
                                     rs1_used_id, rs2_used_id, exp_used));
    if (m_valid === 1'b1) begin
      assert (expect_q.size() > 0)
        else report_failure("m_valid is high but no accepted instruction is pending");
      obs = observe_outputs(expect_q[0]);
      assert (obs === expect_q[0])
        else report_mismatch($sformatf("ID/EX outputs %h, expected %h", obs, expect_q[0]));
    end else begin
      assert (m_valid === 1'b0 && expect_q.size() == 0)
        else report_failure("an accepted instruction did not reach the ID/EX outputs");
      assert ({reg_write_ex, mem_read_ex, mem_write_ex, is_branch_ex,
               is_jal_ex, is_jalr_ex, trap_ex} === '0)
        else report_mismatch("control outputs are not low while m_valid is low");
    end
    acc_now   = s_valid && exp_ready;
    taken_now = m_valid && m_ready;
    flush_now = id_ex_flush;
    if (acc_now) begin
      pending = decode_model(instr_id, pc_id);
    end
  endtask

  task automatic update_model();
    if (flush_now) begin
      expect_q.delete();
    end else begin
      if (taken_now) begin
        void'(expect_q.pop_front());
      end
      if (acc_now) begin
        expect_q.push_back(pending);
      end
    end
    if (acc_now) begin
      accepted++;
    end
    if (reg_write_wb && rd_wb != '0) begin
      model_regs[rd_wb] = rd_data_wb;
    end
  endtask

  initial begin
    #(NUM_TXN * 20 * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", NUM_TXN * 20);
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    s_valid        = 1'b0;
    m_ready        = 1'b0;
    data_hazard_id = 1'b0;
    id_ex_flush    = 1'b0;
    instr_id       = '0;
    pc_id          = '0;
    reg_write_wb   = 1'b0;
    rd_wb          = '0;
    rd_data_wb     = '0;
    accepted       = 0;
    cyc            = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    while (accepted < NUM_TXN || expect_q.size() != 0) begin
      drive_inputs();
      #2;
      check_cycle();
      @(posedge clk);
      #1;
      update_model();
      cyc++;
    end
    #2;
    assert (m_valid === 1'b0)
      else report_failure("m_valid stayed high after the last instruction drained");
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
